// ==== rtl/sdram_pkg.sv ====
package sdram_pkg;

  typedef logic [3:0]  sdram_cmd_t;  // {cs_n, ras_n, cas_n, we_n}
  typedef logic [21:0] bus_addr_t;   // bank 21:20, row 19:10, col 9:0
  typedef logic [15:0] bus_data_t;
  typedef logic [11:0] sdram_addr_t;
  typedef logic [1:0]  bank_t;
  typedef logic [1:0]  byte_sel_t;

  typedef enum logic [3:0] {
    INIT_WAIT, INIT_PRECHARGE, INIT_REFRESH, INIT_REFRESH_WAIT,
    INIT_MODE, INIT_MODE_WAIT, IDLE, REFRESH, ACTIVATE,
    READ_WAIT, READ_WAIT2, READ_WAIT3, RW, PRECHARGE
  } ctrl_state_t;

  localparam sdram_cmd_t CMD_DESL      = 4'b1111;
  localparam sdram_cmd_t CMD_NOP       = 4'b0111;
  localparam sdram_cmd_t CMD_READ      = 4'b0101;
  localparam sdram_cmd_t CMD_WRITE     = 4'b0100;
  localparam sdram_cmd_t CMD_ACTIVATE  = 4'b0011;
  localparam sdram_cmd_t CMD_PRECHARGE = 4'b0010;
  localparam sdram_cmd_t CMD_REFRESH   = 4'b0001;
  localparam sdram_cmd_t CMD_MRS       = 4'b0000;

  localparam int INIT_WAIT_CYCLES   = 2000;  // power-up wait
  localparam int INIT_REFRESH_COUNT = 8;
  localparam int T_RC_CYCLES        = 8;     // nops after refresh
  localparam int T_RCD_CYCLES       = 5;
  localparam int T_RP_CYCLES        = 3;     // init precharge to first refresh
  localparam int REFRESH_INTERVAL   = 780;
  localparam int CAS_LATENCY        = 2;

  localparam sdram_addr_t MODE_WORD = 12'h021;  // cl 2, sequential, bl 2

  localparam int DELAY_W       = $clog2(INIT_WAIT_CYCLES + 1);
  localparam int REFRESH_CNT_W = $clog2(REFRESH_INTERVAL);
  localparam int INIT_REF_W    = $clog2(INIT_REFRESH_COUNT + 1);

  typedef logic [DELAY_W-1:0] delay_t;

endpackage

// ==== rtl/sdram_refresh_timer.sv ====
`timescale 1ns/1ps

module sdram_refresh_timer (
  input  logic clk_i,
  input  logic rst_i,
  input  logic enable_i,
  input  logic refresh_done_i,
  output logic refresh_req_o
);

  import sdram_pkg::*;

  logic [REFRESH_CNT_W-1:0] cnt_q;
  logic                     req_q;
  logic                     cnt_wrap;

  assign cnt_wrap = (cnt_q == REFRESH_CNT_W'(REFRESH_INTERVAL - 1));

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      cnt_q <= '0;
      req_q <= 1'b0;
    end else if (refresh_done_i) begin
      cnt_q <= '0;  // restart interval from the served refresh
      req_q <= 1'b0;
    end else if (enable_i && !req_q) begin
      if (cnt_wrap) begin
        cnt_q <= '0;
        req_q <= 1'b1;  // held until served
      end else begin
        cnt_q <= cnt_q + REFRESH_CNT_W'(1);
      end
    end
  end

  assign refresh_req_o = req_q;

endmodule

// ==== rtl/sdram_ctrl.sv ====
`timescale 1ns/1ps

module sdram_ctrl (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  sdram_pkg::bus_addr_t   adr_i,
  input  sdram_pkg::bus_data_t   dat_i,
  input  logic                   we_i,
  input  sdram_pkg::byte_sel_t   sel_i,
  input  logic                   cyc_i,
  input  logic                   stb_i,
  output logic                   ack_o,
  output sdram_pkg::bus_data_t   dat_o,
  input  logic                   refresh_req_i,
  output logic                   refresh_done_o,
  output logic                   init_done_o,
  output logic                   mem_clk_o,
  output logic                   cke_o,
  output logic                   cs_n_o,
  output logic                   ras_n_o,
  output logic                   cas_n_o,
  output logic                   we_n_o,
  output sdram_pkg::bank_t       ba_o,
  output sdram_pkg::sdram_addr_t addr_o,
  output sdram_pkg::byte_sel_t   dqm_o,
  output sdram_pkg::bus_data_t   dq_o,
  output logic                   dq_oe_o,
  input  sdram_pkg::bus_data_t   dq_i
);

  import sdram_pkg::*;

  ctrl_state_t             state_q, state_d;
  sdram_cmd_t              cmd_q, cmd_d;
  delay_t                  delay_q, delay_d;
  bank_t                   ba_q, ba_d;
  sdram_addr_t             addr_q, addr_d;
  byte_sel_t               dqm_q, dqm_d;
  logic                    dq_oe_q, dq_oe_d;
  logic [INIT_REF_W-1:0]   ref_cnt_q, ref_cnt_d;
  logic                    wr_q, wr_d;
  logic                    init_done_q, init_done_d;
  logic                    cke_q;
  bus_data_t               dq_q;
  bus_data_t               rd_data_q;
  logic                    select;
  logic                    delay_zero;

  assign select     = cyc_i & stb_i;
  assign delay_zero = (delay_q == '0);

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_q     <= INIT_WAIT;
      cmd_q       <= CMD_NOP;
      delay_q     <= delay_t'(INIT_WAIT_CYCLES - 1);
      ba_q        <= '0;
      addr_q      <= '0;
      dqm_q       <= '1;
      dq_oe_q     <= 1'b0;
      ref_cnt_q   <= INIT_REF_W'(INIT_REFRESH_COUNT);
      wr_q        <= 1'b0;
      init_done_q <= 1'b0;
      cke_q       <= 1'b0;
    end else begin
      state_q     <= state_d;
      cmd_q       <= cmd_d;
      delay_q     <= delay_d;
      ba_q        <= ba_d;
      addr_q      <= addr_d;
      dqm_q       <= dqm_d;
      dq_oe_q     <= dq_oe_d;
      ref_cnt_q   <= ref_cnt_d;
      wr_q        <= wr_d;
      init_done_q <= init_done_d;
      cke_q       <= 1'b1;
    end
  end

  // write data and read capture
  always_ff @(posedge clk_i) begin
    if (state_q == ACTIVATE && delay_zero && wr_q) begin
      dq_q <= dat_i;
    end
    if (state_q == READ_WAIT3) begin
      rd_data_q <= dq_i;  // data driven at READ + cl
    end
  end

  always_comb begin
    state_d     = state_q;
    cmd_d       = CMD_NOP;
    delay_d     = delay_q;
    ba_d        = ba_q;
    addr_d      = addr_q;
    dqm_d       = dqm_q;
    dq_oe_d     = 1'b0;
    ref_cnt_d   = ref_cnt_q;
    wr_d        = wr_q;
    init_done_d = init_done_q;
    case (state_q)
      INIT_WAIT: begin
        delay_d = delay_q - delay_t'(1);
        if (delay_zero) begin
          cmd_d   = CMD_PRECHARGE;
          addr_d  = 12'h400;  // a10, all banks
          delay_d = delay_t'(T_RP_CYCLES - 1);
          state_d = INIT_PRECHARGE;
        end
      end
      INIT_PRECHARGE: begin
        delay_d = delay_q - delay_t'(1);
        if (delay_zero) begin
          cmd_d     = CMD_REFRESH;
          ref_cnt_d = ref_cnt_q - INIT_REF_W'(1);
          state_d   = INIT_REFRESH;
        end
      end
      INIT_REFRESH: begin
        delay_d = delay_t'(T_RC_CYCLES - 1);
        state_d = INIT_REFRESH_WAIT;
      end
      INIT_REFRESH_WAIT: begin
        delay_d = delay_q - delay_t'(1);
        if (delay_zero) begin
          if (ref_cnt_q == '0) begin
            cmd_d   = CMD_MRS;
            ba_d    = '0;
            addr_d  = MODE_WORD;
            state_d = INIT_MODE;
          end else begin
            cmd_d     = CMD_REFRESH;
            ref_cnt_d = ref_cnt_q - INIT_REF_W'(1);
            state_d   = INIT_REFRESH;
          end
        end
      end
      INIT_MODE: begin
        delay_d = delay_t'(3);  // four nops after mrs
        state_d = INIT_MODE_WAIT;
      end
      INIT_MODE_WAIT: begin
        delay_d = delay_q - delay_t'(1);
        if (delay_zero) begin
          init_done_d = 1'b1;
          state_d     = IDLE;
        end
      end
      IDLE: begin
        if (refresh_req_i) begin  // refresh wins over a request
          cmd_d   = CMD_REFRESH;
          delay_d = delay_t'(T_RC_CYCLES);
          state_d = REFRESH;
        end else if (select) begin
          cmd_d   = CMD_ACTIVATE;
          ba_d    = adr_i[21:20];
          addr_d  = {2'b00, adr_i[19:10]};  // open row
          wr_d    = we_i;
          delay_d = delay_t'(T_RCD_CYCLES - 1);
          state_d = ACTIVATE;
        end
      end
      REFRESH: begin
        delay_d = delay_q - delay_t'(1);
        if (delay_zero) begin
          state_d = IDLE;
        end
      end
      ACTIVATE: begin
        delay_d = delay_q - delay_t'(1);
        if (delay_zero) begin
          cmd_d  = wr_q ? CMD_WRITE : CMD_READ;
          addr_d = {2'b00, adr_i[9:0]};  // column, a10 low
          dqm_d  = ~sel_i;
          if (wr_q) begin
            dq_oe_d = 1'b1;
            state_d = RW;
          end else begin
            state_d = READ_WAIT;
          end
        end
      end
      READ_WAIT:  state_d = READ_WAIT2;
      READ_WAIT2: state_d = READ_WAIT3;
      READ_WAIT3: state_d = RW;
      RW: begin
        cmd_d   = CMD_PRECHARGE;  // a10 still low, this bank only
        dqm_d   = '1;
        state_d = PRECHARGE;
      end
      PRECHARGE: state_d = IDLE;
      default:   state_d = IDLE;
    endcase
  end

  assign {cs_n_o, ras_n_o, cas_n_o, we_n_o} = cmd_q;

  assign ack_o          = (state_q == RW);
  assign dat_o          = (ack_o && !wr_q) ? rd_data_q : '0;
  assign refresh_done_o = (state_q == IDLE) && refresh_req_i;
  assign init_done_o    = init_done_q;
  assign mem_clk_o      = ~clk_i;  // memory samples on our falling edge
  assign cke_o          = cke_q;
  assign ba_o           = ba_q;
  assign addr_o         = addr_q;
  assign dqm_o          = dqm_q;
  assign dq_o           = dq_q;
  assign dq_oe_o        = dq_oe_q;

endmodule

// ==== rtl/sdram_top.sv ====
`timescale 1ns/1ps

module sdram_top (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  sdram_pkg::bus_addr_t   adr_i,
  input  sdram_pkg::bus_data_t   dat_i,
  input  logic                   we_i,
  input  sdram_pkg::byte_sel_t   sel_i,
  input  logic                   cyc_i,
  input  logic                   stb_i,
  output logic                   ack_o,
  output sdram_pkg::bus_data_t   dat_o,
  output logic                   mem_clk_o,
  output logic                   cke_o,
  output logic                   cs_n_o,
  output logic                   ras_n_o,
  output logic                   cas_n_o,
  output logic                   we_n_o,
  output sdram_pkg::bank_t       ba_o,
  output sdram_pkg::sdram_addr_t addr_o,
  output sdram_pkg::byte_sel_t   dqm_o,
  output sdram_pkg::bus_data_t   dq_o,
  output logic                   dq_oe_o,
  input  sdram_pkg::bus_data_t   dq_i
);

  logic refresh_req;
  logic refresh_done;
  logic init_done;  // timer idles until init finishes

  sdram_ctrl i_ctrl (
    .clk_i, .rst_i, .adr_i, .dat_i, .we_i, .sel_i, .cyc_i, .stb_i,
    .ack_o, .dat_o,
    .refresh_req_i  (refresh_req),
    .refresh_done_o (refresh_done),
    .init_done_o    (init_done),
    .mem_clk_o, .cke_o, .cs_n_o, .ras_n_o, .cas_n_o, .we_n_o,
    .ba_o, .addr_o, .dqm_o, .dq_o, .dq_oe_o, .dq_i
  );

  sdram_refresh_timer i_refresh (
    .clk_i,
    .rst_i,
    .enable_i       (init_done),
    .refresh_done_i (refresh_done),
    .refresh_req_o  (refresh_req)
  );

endmodule

// ==== tests/sdram_model.sv ====
`timescale 1ns/1ps

module sdram_model (
  input  logic                   clk_i,
  input  logic                   cke_i,
  input  logic                   cs_n_i,
  input  logic                   ras_n_i,
  input  logic                   cas_n_i,
  input  logic                   we_n_i,
  input  sdram_pkg::bank_t       ba_i,
  input  sdram_pkg::sdram_addr_t addr_i,
  input  sdram_pkg::byte_sel_t   dqm_i,
  input  sdram_pkg::bus_data_t   dq_i,
  input  logic                   dq_oe_i,
  output sdram_pkg::bus_data_t   dq_o,
  output logic                   error_o
);

  import sdram_pkg::*;

  localparam int MRS_STEP        = INIT_REFRESH_COUNT + 1;
  localparam int DONE_STEP       = INIT_REFRESH_COUNT + 2;
  localparam int REFRESH_GAP_MAX = REFRESH_INTERVAL + 25;

  bus_data_t   mem [logic [23:0]];  // {bank, row, column}
  sdram_addr_t open_row [4];
  logic [3:0]  open_banks = '0;
  sdram_cmd_t  cmd;
  int          init_step = 0;
  int          nops = 0;  // nop cycles since last command
  int          since_act = 0;
  int          since_ref = 0;
  int          since_rw = 0;
  logic        pre_due = 1'b0;
  logic        last_ref = 1'b0;
  int          rd_cnt = 0;
  bus_data_t   rd_word = '0;
  bus_data_t   dq_q = '0;
  logic        err_q = 1'b0;
  logic [23:0] key;
  bus_data_t   word;

  assign cmd     = {cs_n_i, ras_n_i, cas_n_i, we_n_i};
  assign dq_o    = dq_q;
  assign error_o = err_q;

  function automatic bus_data_t fill_word(input logic [23:0] k);
    return k[15:0] ^ {8'h00, k[23:16]};  // never-written location
  endfunction

  task automatic flag_violation(input string what);
    $display("SDRAM model: %s (ba %h addr %h)", what, ba_i, addr_i);
    err_q = 1'b1;
  endtask

  // memory clock is inverted, so pins are stable here
  always @(posedge clk_i) begin
    if (rd_cnt != 0) begin
      rd_cnt = rd_cnt - 1;
      if (rd_cnt == 0) begin
        dq_q = rd_word;  // cas latency reached
      end
    end
    since_act = since_act + 1;
    if (init_step == DONE_STEP) begin
      since_ref = since_ref + 1;
      assert (since_ref <= REFRESH_GAP_MAX)
        else flag_violation("refresh overdue");
    end
    if (pre_due) begin
      since_rw = since_rw + 1;
      assert (since_rw <= 4)
        else flag_violation("no PRECHARGE within 4 cycles of READ or WRITE");
    end
    if (cke_i !== 1'b1 || cs_n_i !== 1'b0 || cmd == CMD_NOP) begin
      nops = nops + 1;
    end else begin
      if (last_ref) begin
        assert (nops >= T_RC_CYCLES)
          else flag_violation("command too soon after REFRESH");
      end
      if (init_step == 0) begin
        assert (cmd == CMD_PRECHARGE && addr_i[10])
          else flag_violation("init must start with PRECHARGE all");
      end else if (init_step < MRS_STEP) begin
        assert (cmd == CMD_REFRESH)
          else flag_violation("expected init REFRESH");
      end else if (init_step == MRS_STEP) begin
        assert (cmd == CMD_MRS && addr_i == MODE_WORD && ba_i == 2'b00)
          else flag_violation("expected MRS with the mode word on bank 0");
      end
      if (init_step < DONE_STEP) begin
        init_step = init_step + 1;
      end
      case (cmd)
        CMD_ACTIVATE: begin
          assert (open_banks == '0)
            else flag_violation("ACTIVATE while a bank is open");
          open_banks[ba_i] = 1'b1;
          open_row[ba_i]   = addr_i;
          since_act        = 0;
        end
        CMD_READ, CMD_WRITE: begin
          assert (open_banks[ba_i] && since_act == T_RCD_CYCLES)
            else flag_violation("READ or WRITE not T_RCD after ACTIVATE");
          key      = {ba_i, open_row[ba_i], addr_i[9:0]};
          word     = mem.exists(key) ? mem[key] : fill_word(key);
          pre_due  = 1'b1;
          since_rw = 0;
          if (cmd == CMD_WRITE) begin
            assert (dq_oe_i)
              else flag_violation("WRITE without the data output enabled");
            if (!dqm_i[0])
              word[7:0] = dq_i[7:0];
            if (!dqm_i[1])
              word[15:8] = dq_i[15:8];
            mem[key] = word;
          end else begin
            rd_word = word;
            rd_cnt  = CAS_LATENCY;
          end
        end
        CMD_PRECHARGE: begin
          if (addr_i[10])
            open_banks = '0;
          else
            open_banks[ba_i] = 1'b0;
          pre_due = 1'b0;
        end
        CMD_REFRESH: begin
          assert (open_banks == '0)
            else flag_violation("REFRESH while a bank is open");
          since_ref = 0;
        end
        CMD_MRS: since_ref = 0;  // interval counted from end of init
        default: flag_violation("unsupported command");
      endcase
      last_ref = (cmd == CMD_REFRESH);
      nops     = 0;
    end
  end

endmodule

// ==== tests/sdram_properties.sv ====
`timescale 1ns/1ps

module sdram_properties (
  input logic                  clk_i,
  input logic                  rst_i,
  input logic                  cyc_i,
  input logic                  stb_i,
  input logic                  we_i,
  input logic                  ack_i,
  input sdram_pkg::bus_data_t  rd_dat_i,
  input sdram_pkg::sdram_cmd_t cmd_i,
  input sdram_pkg::bank_t      ba_i,
  input logic                  cke_i
);

  import sdram_pkg::*;

  logic access_cmd;

  assign access_cmd = (cmd_i == CMD_READ) || (cmd_i == CMD_WRITE);

  reset_quiet: assert property (@(posedge clk_i)
    rst_i |-> (cmd_i == CMD_NOP) && !cke_i && !ack_i)
    else $error("command, cke or ack active during reset");

  cke_after_reset: assert property (@(posedge clk_i) disable iff (rst_i)
    $past(!rst_i) |-> cke_i)
    else $error("cke low after reset");

  ack_single: assert property (@(posedge clk_i) disable iff (rst_i)
    ack_i |=> !ack_i)
    else $error("ack wider than one cycle");

  ack_in_cycle: assert property (@(posedge clk_i) disable iff (rst_i)
    ack_i |-> cyc_i && stb_i)
    else $error("ack without a request");

  write_ack_cmd: assert property (@(posedge clk_i) disable iff (rst_i)
    (cmd_i == CMD_WRITE) |-> ack_i && we_i)
    else $error("WRITE without its ack");

  write_cmd_ack: assert property (@(posedge clk_i) disable iff (rst_i)
    ack_i && we_i |-> (cmd_i == CMD_WRITE))
    else $error("write ack without WRITE");

  read_ack_delay: assert property (@(posedge clk_i) disable iff (rst_i)
    (cmd_i == CMD_READ) |-> ##3 (ack_i && !we_i))
    else $error("read ack not 3 cycles after READ");

  dat_quiet: assert property (@(posedge clk_i) disable iff (rst_i)
    !ack_i |-> (rd_dat_i == '0))
    else $error("dat_o not zero outside ack");

  act_to_rw: assert property (@(posedge clk_i) disable iff (rst_i)
    (cmd_i == CMD_ACTIVATE) |-> ##T_RCD_CYCLES
      (access_cmd && ba_i == $past(ba_i, T_RCD_CYCLES)))
    else $error("READ or WRITE not T_RCD after ACTIVATE to the same bank");

endmodule

bind sdram_top sdram_properties i_props (
  .clk_i    (clk_i),
  .rst_i    (rst_i),
  .cyc_i    (cyc_i),
  .stb_i    (stb_i),
  .we_i     (we_i),
  .ack_i    (ack_o),
  .rd_dat_i (dat_o),
  .cmd_i    ({cs_n_o, ras_n_o, cas_n_o, we_n_o}),
  .ba_i     (ba_o),
  .cke_i    (cke_o)
);

// ==== tests/tb_sdram.sv ====
`timescale 1ns/1ps

module tb_sdram;

  import sdram_pkg::*;

  localparam int RANDOM_ACCESSES = 150;
  localparam int MAX_ACCESSES    = 200;
  localparam int ACCESS_CYCLES   = 25;
  localparam int IDLE_STRETCH    = REFRESH_INTERVAL + 220;
  localparam int TIMEOUT_CYCLES  = INIT_WAIT_CYCLES + MAX_ACCESSES * ACCESS_CYCLES
                                   + IDLE_STRETCH + 500;

  logic        clk_i;
  logic        rst_i;
  bus_addr_t   adr_i;
  bus_data_t   dat_i;
  logic        we_i;
  byte_sel_t   sel_i;
  logic        cyc_i;
  logic        stb_i;
  logic        ack_o;
  bus_data_t   dat_o;
  logic        mem_clk_o;
  logic        cke_o;
  logic        cs_n_o;
  logic        ras_n_o;
  logic        cas_n_o;
  logic        we_n_o;
  bank_t       ba_o;
  sdram_addr_t addr_o;
  byte_sel_t   dqm_o;
  bus_data_t   dq_o;
  logic        dq_oe_o;
  bus_data_t   dq_i;
  logic        model_error;
  logic [31:0] lcg_state;
  int          cycle_count = 0;
  bus_data_t   exp_mem [bus_addr_t];
  bus_addr_t   written_q [$];

  sdram_top i_sdram_top (.*);

  sdram_model i_model (
    .clk_i   (mem_clk_o),
    .cke_i   (cke_o),
    .cs_n_i  (cs_n_o),
    .ras_n_i (ras_n_o),
    .cas_n_i (cas_n_o),
    .we_n_i  (we_n_o),
    .ba_i    (ba_o),
    .addr_i  (addr_o),
    .dqm_i   (dqm_o),
    .dq_i    (dq_o),
    .dq_oe_i (dq_oe_o),
    .dq_o    (dq_i),
    .error_o (model_error)
  );

  always #4 clk_i = ~clk_i;

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Test failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      report_failure("timeout, the accesses did not complete in time");
    end
  end

  always @(posedge model_error) begin
    report_failure("SDRAM model reported a protocol violation");
  end

  task automatic bus_access(input logic write, input bus_addr_t adr, input bus_data_t data,
                            input byte_sel_t sel, output bus_data_t rdata);
    @(posedge clk_i);
    #1;
    adr_i = adr;
    dat_i = data;
    sel_i = sel;
    we_i  = write;
    cyc_i = 1'b1;
    stb_i = 1'b1;
    do @(negedge clk_i); while (!ack_o);
    rdata = dat_o;
    @(posedge clk_i);
    #1;
    cyc_i = 1'b0;
    stb_i = 1'b0;
    we_i  = 1'b0;
  endtask

  task automatic write_word(input bus_addr_t adr, input bus_data_t data, input byte_sel_t sel);
    bus_data_t ignored;
    bus_data_t word;
    bus_access(1'b1, adr, data, sel, ignored);
    word = exp_mem.exists(adr) ? exp_mem[adr] : 16'h0000;
    if (sel[0])
      word[7:0] = data[7:0];
    if (sel[1])
      word[15:8] = data[15:8];
    if (!exp_mem.exists(adr))
      written_q.push_back(adr);
    exp_mem[adr] = word;
  endtask

  task automatic read_word(input bus_addr_t adr);
    bus_data_t got;
    bus_access(1'b0, adr, 16'h0000, 2'b11, got);
    assert (got === exp_mem[adr])
      else report_failure($sformatf("CHECK FAILED dat_o expected %h actual %h (adr %h)",
                                    exp_mem[adr], got, adr));
  endtask

  initial begin
    logic [31:0] r;
    logic [31:0] r2;
    bus_addr_t   adr;
    byte_sel_t   sel;
    int          idx;
    clk_i     = 1'b0;
    rst_i     = 1'b1;
    adr_i     = '0;
    dat_i     = '0;
    we_i      = 1'b0;
    sel_i     = '0;
    cyc_i     = 1'b0;
    stb_i     = 1'b0;
    lcg_state = 32'h70f6_a4ea;
    repeat (5) @(posedge clk_i);
    #1;
    rst_i = 1'b0;

    // same column in all banks and in a second row
    for (int b = 0; b < 4; b++) begin
      r = next_random();
      write_word({b[1:0], 10'h155, 10'h2aa}, r[15:0], 2'b11);
    end
    r = next_random();
    write_word({2'b00, 10'h0aa, 10'h2aa}, r[15:0], 2'b11);
    for (int k = 0; k < written_q.size(); k++)
      read_word(written_q[k]);

    for (int i = 0; i < RANDOM_ACCESSES; i++) begin
      r = next_random();
      if (i == RANDOM_ACCESSES / 2) begin
        repeat (IDLE_STRETCH) @(posedge clk_i);  // refresh must still come
      end
      if (i < 30 || r[31:30] == 2'd0) begin
        r2  = next_random();
        adr = r2[21:0];
        write_word(adr, r[15:0], 2'b11);  // first writes fill the whole word
      end else begin
        idx = r[29:0] % written_q.size();
        adr = written_q[idx];
        if (r[31:30] == 2'd1) begin
          sel = (r[17:16] == 2'b00) ? 2'b01 : r[17:16];
          write_word(adr, r[15:0], sel);
        end else begin
          read_word(adr);
        end
      end
    end

    if (model_error) begin
      report_failure("SDRAM model reported a protocol violation");
    end else begin
      $display("Test passed");
      $finish;
    end
  end

endmodule

// ==== all.f ====
rtl/sdram_pkg.sv
rtl/sdram_refresh_timer.sv
rtl/sdram_ctrl.sv
rtl/sdram_top.sv
tests/sdram_model.sv
tests/sdram_properties.sv
tests/tb_sdram.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_sdram
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= Test failed
PASS_MSG  ?= Test passed

SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation FAILED"; exit 1; \
	elif grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ok"; \
	else echo "simulation ended without a result"; exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
